// ==== sources.f ====
+incdir+verif
rtl/isa_pkg.sv
rtl/sb_pkg.sv
rtl/gpr_regfile.sv
rtl/clobber_table.sv
rtl/operand_forward.sv
rtl/issue_stage.sv
verif/issue_stage_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := issue_stage_tb
FILELIST  := sources.f

BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard verif/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "no pass message in log"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/issue_model.svh ====
`ifndef ISSUE_MODEL_SVH
`define ISSUE_MODEL_SVH

// ------------------------------
// reference model of the issue rules
// ------------------------------

// unit that will write r as seen by the youngest issued slot
// x0 never has a writer
function automatic fu_t writer_unit(input sb_entry_t sb [Depth], input logic [4:0] r);
  fu_t f;
  f = FU_NONE;
  for (int i = 0; i < Depth; i++) begin
    if (sb[i].issued && (sb[i].rd == r)) begin
      f = sb[i].fu;
    end
  end
  if (r == 5'd0) begin
    f = FU_NONE;
  end
  return f;
endfunction

// wb ports in port order come first and finished slots after them
// returns {hit, data}
function automatic logic [32:0] forward_lookup(input sb_entry_t sb [Depth],
                                               input wb_port_t wb [WbPorts],
                                               input logic [4:0] r);
  for (int p = 0; p < WbPorts; p++) begin
    if (wb[p].valid && (int'(wb[p].trans_id) < Depth) && sb[wb[p].trans_id].issued
        && (sb[wb[p].trans_id].rd == r)) begin
      return {1'b1, wb[p].data};
    end
  end
  for (int i = 0; i < Depth; i++) begin
    if (sb[i].issued && sb[i].valid && (sb[i].rd == r)) begin
      return {1'b1, sb[i].result};
    end
  end
  return {1'b0, 32'd0};
endfunction

function automatic logic fu_blocked(input fu_t fu, input logic flu, input logic lsu,
                                    input logic mdu_q);
  case (fu)
    FU_ALU, FU_BU, FU_CSR: return !flu || mdu_q;
    FU_MDU:                return !flu;
    FU_LOAD, FU_STORE:     return !lsu;
    default:               return 1'b0;
  endcase
endfunction

// expected issue_ready_o for the current inputs
function automatic logic ready_expected(input decoder_t in, input logic valid,
                                        input sb_entry_t sb [Depth],
                                        input wb_port_t wb [WbPorts],
                                        input logic flu, input logic lsu, input logic mdu_q,
                                        input logic we, input logic [4:0] waddr);
  logic [32:0] f1;
  logic [32:0] f2;
  logic        raw;
  logic        waw;
  f1 = forward_lookup(sb, wb, in.rs1);
  f2 = forward_lookup(sb, wb, in.rs2);
  raw = ((writer_unit(sb, in.rs1) != FU_NONE) && !f1[32])
     || ((writer_unit(sb, in.rs2) != FU_NONE) && !f2[32]);
  // commit on rd in the same cycle releases the hazard
  waw = (in.rd != 5'd0) && (writer_unit(sb, in.rd) != FU_NONE) && !(we && (waddr == in.rd));
  return valid && !fu_blocked(in.fu, flu, lsu, mdu_q) && (!(raw || waw) || in.ex_valid);
endfunction

// {alu, branch, lsu, mdu, csr}
function automatic logic [4:0] strobe_pattern(input fu_t fu);
  case (fu)
    FU_ALU:            return 5'b10000;
    FU_BU:             return 5'b01000;
    FU_LOAD, FU_STORE: return 5'b00100;
    FU_MDU:            return 5'b00010;
    FU_CSR:            return 5'b00001;
    default:           return 5'b00000;
  endcase
endfunction

// bundle registered towards execute
function automatic fu_data_t bundle_expected(input decoder_t in, input sb_entry_t sb [Depth],
                                             input wb_port_t wb [WbPorts],
                                             input logic [31:0] regs [32]);
  fu_data_t    d;
  logic [32:0] f1;
  logic [32:0] f2;
  f1 = forward_lookup(sb, wb, in.rs1);
  f2 = forward_lookup(sb, wb, in.rs2);
  d.fu       = in.fu;
  d.op       = in.op;
  d.imm      = in.imm;
  d.trans_id = in.trans_id;
  d.operand_a = regs[in.rs1];
  d.operand_b = regs[in.rs2];
  if ((writer_unit(sb, in.rs1) != FU_NONE) && f1[32]) d.operand_a = f1[31:0];
  if ((writer_unit(sb, in.rs2) != FU_NONE) && f2[32]) d.operand_b = f2[31:0];
  if (in.use_pc) d.operand_a = in.pc;
  if (in.use_zimm) d.operand_a = {27'd0, in.rs1};
  if (in.use_imm && (in.fu != FU_STORE) && (in.fu != FU_BU)) d.operand_b = in.imm;
  return d;
endfunction

`endif

// ==== verif/issue_stage_tb.sv ====
module issue_stage_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import isa_pkg::*;
  import sb_pkg::*;

  localparam int Depth   = 8;
  localparam int WbPorts = 2;
  localparam int ClockNs = 40;
  // regfile 24, forward 30, waw 24, busy 16, dispatch 40, random 400
  localparam int PlannedCycles = 534;
  localparam int TimeoutNs = (PlannedCycles + 100) * ClockNs;

  logic        clock;
  logic        reset;
  logic        flush;
  decoder_t    instr;
  logic        instr_valid;
  logic        issue_ready;
  sb_entry_t   sb_entries [Depth];
  wb_port_t    wb [WbPorts];
  logic        flu_ready;
  logic        lsu_ready;
  logic        gpr_we;
  logic [4:0]  gpr_waddr;
  logic [31:0] gpr_wdata;
  fu_data_t    fu_data;
  logic        alu_valid;
  logic        branch_valid;
  logic        lsu_valid;
  logic        mdu_valid;
  logic        csr_valid;
  logic [31:0] branch_pc;
  logic        is_compressed;
  bp_t         branch_predict;

  // model state
  logic [31:0] shadow_regs [32];
  logic        exp_mdu_q = 1'b0;
  logic [31:0] exp_branch_pc = '0;
  logic        exp_compressed = 1'b0;
  bp_t         exp_bp = '0;
  logic        last_ready = 1'b0;
  logic [4:0]  last_strobe = '0;
  logic [31:0] lcg_state = 32'h6ccf36aa;
  int          checks_run = 0;
  int          errors = 0;
  int          test_errors = 0;

  `include "issue_model.svh"

  issue_stage #(
    .ScoreboardDepth (Depth),
    .WriteBackPorts  (WbPorts)
  ) dut (
    .clock            (clock),
    .reset            (reset),
    .flush_i          (flush),
    .issue_instr_i    (instr),
    .issue_valid_i    (instr_valid),
    .issue_ready_o    (issue_ready),
    .sb_entries_i     (sb_entries),
    .wb_i             (wb),
    .flu_ready_i      (flu_ready),
    .lsu_ready_i      (lsu_ready),
    .gpr_we_i         (gpr_we),
    .gpr_waddr_i      (gpr_waddr),
    .gpr_wdata_i      (gpr_wdata),
    .fu_data_o        (fu_data),
    .alu_valid_o      (alu_valid),
    .branch_valid_o   (branch_valid),
    .lsu_valid_o      (lsu_valid),
    .mdu_valid_o      (mdu_valid),
    .csr_valid_o      (csr_valid),
    .branch_pc_o      (branch_pc),
    .is_compressed_o  (is_compressed),
    .branch_predict_o (branch_predict)
  );

  initial clock = 1'b0;
  always #(ClockNs / 2) clock = ~clock;

  // ------------------------------
  // random numbers
  // ------------------------------
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // low lcg bits are weak so only the upper ones are used
  function automatic logic [31:0] rand_range(input int n);
    return (next_random() >> 8) % 32'(n);
  endfunction

  function automatic logic rand_bit();
    logic [31:0] v;
    v = next_random();
    return v[31];
  endfunction

  task automatic check_value(input string test, input string what,
                             input logic [127:0] exp, input logic [127:0] act);
    checks_run++;
    assert (act === exp) else begin
      $display("FAILED %s: %s expected %h actual %h", test, what, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic end_test(input string test);
    $display("test %s finished with %0d errors", test, test_errors);
    test_errors = 0;
  endtask

  // ------------------------------
  // stimulus helpers
  // ------------------------------
  task automatic clear_inputs();
    instr_valid = 1'b0;
    instr       = '0;
    flush       = 1'b0;
    flu_ready   = 1'b1;
    lsu_ready   = 1'b1;
    gpr_we      = 1'b0;
    gpr_waddr   = '0;
    gpr_wdata   = '0;
    for (int i = 0; i < Depth; i++) sb_entries[i] = '0;
    for (int p = 0; p < WbPorts; p++) wb[p] = '0;
  endtask

  // register-read op without operand select flags
  task automatic plain_instr(input fu_t fu, input logic [4:0] rs1, input logic [4:0] rs2,
                             input logic [4:0] rd);
    instr          = '0;
    instr.fu       = fu;
    instr.op       = op_t'(6'(rand_range(35)));
    instr.rs1      = rs1;
    instr.rs2      = rs2;
    instr.rd       = rd;
    instr.pc       = next_random();
    instr.imm      = next_random();
    instr.trans_id = 3'(rand_range(8));
  endtask

  task automatic random_instr();
    plain_instr(fu_t'(3'(rand_range(7))), 5'(rand_range(8)), 5'(rand_range(8)),
                5'(rand_range(8)));
    instr.use_imm       = rand_bit();
    instr.use_pc        = rand_range(4) == 0;
    instr.use_zimm      = rand_range(4) == 0;
    instr.is_compressed = rand_bit();
    instr.ex_valid      = rand_range(8) == 0;
    instr.bp.cf         = cf_t'(2'(rand_range(4)));
    instr.bp.target     = next_random();
  endtask

  // small rd span makes collisions common
  task automatic random_scoreboard(input int rd_span);
    for (int i = 0; i < Depth; i++) begin
      sb_entries[i].issued = rand_range(4) == 0;
      sb_entries[i].valid  = rand_bit();
      sb_entries[i].rd     = 5'(rand_range(rd_span));
      sb_entries[i].fu     = fu_t'(3'(rand_range(7)));
      sb_entries[i].result = next_random();
    end
    for (int p = 0; p < WbPorts; p++) begin
      wb[p].valid    = rand_bit();
      wb[p].trans_id = 3'(rand_range(8));
      wb[p].data     = next_random();
    end
  endtask

  // runs from 2 ns after one edge to 2 ns after the next one
  task automatic run_cycle(input string name);
    logic       exp_ready;
    logic [4:0] exp_strobe;
    fu_data_t   exp_data;
    #(ClockNs / 2 - 2);
    exp_ready = ready_expected(instr, instr_valid, sb_entries, wb, flu_ready, lsu_ready,
                               exp_mdu_q, gpr_we, gpr_waddr);
    exp_data = bundle_expected(instr, sb_entries, wb, shadow_regs);
    exp_strobe = 5'd0;
    if (exp_ready && !instr.ex_valid && !flush) exp_strobe = strobe_pattern(instr.fu);
    last_ready = issue_ready;
    check_value(name, "issue_ready_o", 128'(exp_ready), 128'(issue_ready));
    if (instr.fu == FU_BU) begin
      exp_branch_pc  = instr.pc;
      exp_compressed = instr.is_compressed;
      exp_bp         = instr.bp;
    end
    @(posedge clock);
    #1;
    last_strobe = {alu_valid, branch_valid, lsu_valid, mdu_valid, csr_valid};
    check_value(name, "unit strobes", 128'(exp_strobe), 128'(last_strobe));
    check_value(name, "fu_data_o", 128'(exp_data), 128'(fu_data));
    check_value(name, "branch_pc_o", 128'(exp_branch_pc), 128'(branch_pc));
    check_value(name, "is_compressed_o", 128'(exp_compressed), 128'(is_compressed));
    check_value(name, "branch_predict_o", 128'(exp_bp), 128'(branch_predict));
    // commit landed at this edge
    if (gpr_we && (gpr_waddr != 5'd0)) shadow_regs[gpr_waddr] = gpr_wdata;
    exp_mdu_q = exp_strobe[1];
    #1;
  endtask

  // ------------------------------
  // tests
  // ------------------------------
  task automatic regfile_readback();
    logic [4:0] r1;
    logic [4:0] r2;
    for (int n = 0; n < 12; n++) begin
      r1 = 5'(rand_range(32));
      r2 = (n % 3 == 0) ? 5'd0 : 5'(rand_range(32));
      clear_inputs();
      gpr_we    = 1'b1;
      gpr_waddr = r1;
      gpr_wdata = next_random();
      run_cycle("regfile");
      clear_inputs();
      plain_instr(FU_ALU, r1, r2, 5'd0);
      instr_valid = 1'b1;
      run_cycle("regfile");
      check_value("regfile", "operand_a vs shadow", 128'(shadow_regs[r1]),
                  128'(fu_data.operand_a));
      // x0 always reads zero
      if (r2 == 5'd0) check_value("regfile", "x0 operand_b", 128'd0, 128'(fu_data.operand_b));
    end
    end_test("regfile");
  endtask

  task automatic forward_priority();
    for (int n = 0; n < 30; n++) begin
      clear_inputs();
      random_scoreboard(4);
      plain_instr(FU_ALU, 5'(rand_range(4)), 5'(rand_range(4)), 5'd0);
      instr_valid = 1'b1;
      run_cycle("forward");
    end
    end_test("forward");
  endtask

  task automatic waw_release();
    logic [4:0] rd;
    int         k;
    for (int n = 0; n < 8; n++) begin
      rd = 5'(rand_range(31) + 1);
      k  = int'(rand_range(Depth));
      clear_inputs();
      sb_entries[k].issued = 1'b1;
      sb_entries[k].fu     = FU_ALU;
      sb_entries[k].rd     = rd;
      plain_instr(FU_ALU, 5'd0, 5'd0, rd);
      instr_valid = 1'b1;
      run_cycle("waw");
      check_value("waw", "ready with rd clobbered", 128'd0, 128'(last_ready));
      run_cycle("waw");
      check_value("waw", "ready with rd clobbered", 128'd0, 128'(last_ready));
      gpr_we    = 1'b1;
      gpr_waddr = rd;
      gpr_wdata = next_random();
      run_cycle("waw");
      check_value("waw", "ready on commit of rd", 128'd1, 128'(last_ready));
    end
    end_test("waw");
  endtask

  task automatic unit_busy();
    // mdu last so its strobe blocks nothing in the loop
    fu_t lsu_fus [6] = '{FU_ALU, FU_BU, FU_LOAD, FU_STORE, FU_CSR, FU_MDU};
    fu_t flu_fus [3] = '{FU_ALU, FU_BU, FU_CSR};
    foreach (lsu_fus[i]) begin
      clear_inputs();
      lsu_ready = 1'b0;
      plain_instr(lsu_fus[i], 5'd0, 5'd0, 5'd0);
      instr_valid = 1'b1;
      run_cycle("busy");
      check_value("busy", "ready with lsu low",
                  128'((lsu_fus[i] != FU_LOAD) && (lsu_fus[i] != FU_STORE)), 128'(last_ready));
    end
    foreach (flu_fus[i]) begin
      clear_inputs();
      plain_instr(FU_MDU, 5'd0, 5'd0, 5'd0);
      instr_valid = 1'b1;
      run_cycle("busy");
      check_value("busy", "mdu strobe", 128'(5'b00010), 128'(last_strobe));
      plain_instr(flu_fus[i], 5'd0, 5'd0, 5'd0);
      run_cycle("busy");
      check_value("busy", "ready behind mdu strobe", 128'd0, 128'(last_ready));
      run_cycle("busy");
      check_value("busy", "ready after mdu strobe", 128'd1, 128'(last_ready));
    end
    // excepted op passes its waw hazard and starts no unit
    clear_inputs();
    sb_entries[0].issued = 1'b1;
    sb_entries[0].fu     = FU_ALU;
    sb_entries[0].rd     = 5'd3;
    plain_instr(FU_LOAD, 5'd3, 5'd0, 5'd3);
    instr.ex_valid = 1'b1;
    instr_valid    = 1'b1;
    run_cycle("busy");
    check_value("busy", "ready with ex_valid", 128'd1, 128'(last_ready));
    check_value("busy", "strobes with ex_valid", 128'd0, 128'(last_strobe));
    end_test("busy");
  endtask

  task automatic dispatch_select();
    for (int n = 0; n < 40; n++) begin
      clear_inputs();
      random_instr();
      instr.ex_valid = 1'b0;
      flush          = rand_range(4) == 0;
      instr_valid    = 1'b1;
      run_cycle("dispatch");
    end
    end_test("dispatch");
  endtask

  task automatic random_mix();
    for (int n = 0; n < 400; n++) begin
      // a waiting instruction is held until it transfers
      if (!(instr_valid && !last_ready)) begin
        random_instr();
        instr_valid = rand_range(4) != 0;
      end
      random_scoreboard(8);
      flu_ready = rand_range(8) != 0;
      lsu_ready = rand_range(8) != 0;
      gpr_we    = rand_bit();
      gpr_waddr = 5'(rand_range(8));
      gpr_wdata = next_random();
      flush     = rand_range(8) == 0;
      run_cycle("random");
    end
    end_test("random");
  endtask

  // ------------------------------
  // main sequence and watchdog
  // ------------------------------
  initial begin
    for (int r = 0; r < 32; r++) shadow_regs[r] = '0;
    clear_inputs();
    reset = 1'b1;
    repeat (4) @(posedge clock);
    #2;
    reset = 1'b0;
    regfile_readback();
    forward_priority();
    waw_release();
    unit_busy();
    dispatch_select();
    random_mix();
    $display("summary: %0d checks, %0d errors", checks_run, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    #(TimeoutNs);
    $display("watchdog expired, the tests did not finish in time");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== rtl/issue_stage.sv ====
module issue_stage #(
  parameter int ScoreboardDepth = 8,
  parameter int WriteBackPorts  = 2
) (
  input  logic               clock,
  input  logic               reset,
  input  logic               flush_i,
  // issue handshake from decode
  input  isa_pkg::decoder_t  issue_instr_i,
  input  logic               issue_valid_i,
  output logic               issue_ready_o,
  // scoreboard view
  input  sb_pkg::sb_entry_t  sb_entries_i [ScoreboardDepth],
  input  sb_pkg::wb_port_t   wb_i [WriteBackPorts],
  // unit levels
  input  logic               flu_ready_i,
  input  logic               lsu_ready_i,
  // commit write
  input  logic               gpr_we_i,
  input  logic [4:0]         gpr_waddr_i,
  input  logic [31:0]        gpr_wdata_i,
  // towards execute
  output isa_pkg::fu_data_t  fu_data_o,
  output logic               alu_valid_o,
  output logic               branch_valid_o,
  output logic               lsu_valid_o,
  output logic               mdu_valid_o,
  output logic               csr_valid_o,
  output logic [31:0]        branch_pc_o,
  output logic               is_compressed_o,
  output isa_pkg::bp_t       branch_predict_o
);

  import isa_pkg::*;

  // one start pulse per unit
  typedef struct packed {
    logic alu;
    logic branch;
    logic lsu;
    logic mdu;
    logic csr;
  } strobe_t;

  logic [31:0] gpr_rdata_1;
  logic [31:0] gpr_rdata_2;
  logic        rs1_raw;
  logic        rs2_raw;
  logic        rd_waw;
  logic        rs1_hit;
  logic        rs2_hit;
  logic [31:0] rs1_fwd_data;
  logic [31:0] rs2_fwd_data;
  logic        fu_busy;
  logic        stall_raw;
  logic        stall_waw;
  logic        transfer;
  strobe_t     strobe_n;
  strobe_t     strobe_q;
  fu_data_t    fu_data_n;

  // ------------------------------
  // operand sources
  // ------------------------------
  gpr_regfile u_gpr_regfile (
    .clock     (clock),
    .reset     (reset),
    .raddr_1_i (issue_instr_i.rs1),
    .raddr_2_i (issue_instr_i.rs2),
    .waddr_i   (gpr_waddr_i),
    .wdata_i   (gpr_wdata_i),
    .we_i      (gpr_we_i),
    .rdata_1_o (gpr_rdata_1),
    .rdata_2_o (gpr_rdata_2)
  );

  clobber_table #(
    .ScoreboardDepth (ScoreboardDepth)
  ) u_clobber_table (
    .sb_entries_i (sb_entries_i),
    .rs1_i        (issue_instr_i.rs1),
    .rs2_i        (issue_instr_i.rs2),
    .rd_i         (issue_instr_i.rd),
    .rs1_raw_o    (rs1_raw),
    .rs2_raw_o    (rs2_raw),
    .rd_waw_o     (rd_waw)
  );

  operand_forward #(
    .ScoreboardDepth (ScoreboardDepth),
    .WriteBackPorts  (WriteBackPorts)
  ) u_fwd_rs1 (
    .clock        (clock),
    .rs_i         (issue_instr_i.rs1),
    .sb_entries_i (sb_entries_i),
    .wb_i         (wb_i),
    .hit_o        (rs1_hit),
    .data_o       (rs1_fwd_data)
  );

  operand_forward #(
    .ScoreboardDepth (ScoreboardDepth),
    .WriteBackPorts  (WriteBackPorts)
  ) u_fwd_rs2 (
    .clock        (clock),
    .rs_i         (issue_instr_i.rs2),
    .sb_entries_i (sb_entries_i),
    .wb_i         (wb_i),
    .hit_o        (rs2_hit),
    .data_o       (rs2_fwd_data)
  );

  // ------------------------------
  // unit busy and issue decision
  // ------------------------------
  // mdu in flight blocks the shared flu result path
  always_comb begin
    case (issue_instr_i.fu)
      FU_ALU, FU_BU, FU_CSR: fu_busy = !flu_ready_i || strobe_q.mdu;
      FU_MDU:                fu_busy = !flu_ready_i;
      FU_LOAD, FU_STORE:     fu_busy = !lsu_ready_i;
      default:               fu_busy = 1'b0;
    endcase
  end

  // raw only stalls when nothing can be forwarded
  assign stall_raw = (rs1_raw && !rs1_hit) || (rs2_raw && !rs2_hit);
  // commit writing rd this cycle frees it
  assign stall_waw = rd_waw && !(gpr_we_i && (gpr_waddr_i == issue_instr_i.rd));

  // excepted instructions pass regardless of hazards
  assign issue_ready_o = issue_valid_i && !fu_busy
                      && (!(stall_raw || stall_waw) || issue_instr_i.ex_valid);
  assign transfer = issue_valid_i && issue_ready_o;

  // ------------------------------
  // operand mux
  // ------------------------------
  always_comb begin
    fu_data_n.fu       = issue_instr_i.fu;
    fu_data_n.op       = issue_instr_i.op;
    fu_data_n.imm      = issue_instr_i.imm;
    fu_data_n.trans_id = issue_instr_i.trans_id;
    // forward only for clobbered operands
    fu_data_n.operand_a = (rs1_raw && rs1_hit) ? rs1_fwd_data : gpr_rdata_1;
    fu_data_n.operand_b = (rs2_raw && rs2_hit) ? rs2_fwd_data : gpr_rdata_2;
    if (issue_instr_i.use_pc) begin
      fu_data_n.operand_a = issue_instr_i.pc;
    end
    // csr immediate form, rs1 field as value
    if (issue_instr_i.use_zimm) begin
      fu_data_n.operand_a = {27'd0, issue_instr_i.rs1};
    end
    // stores and branches keep rs2 in operand_b
    if (issue_instr_i.use_imm && (issue_instr_i.fu != FU_STORE)
        && (issue_instr_i.fu != FU_BU)) begin
      fu_data_n.operand_b = issue_instr_i.imm;
    end
  end

  // unit select
  always_comb begin
    strobe_n = '0;
    if (transfer && !issue_instr_i.ex_valid && !flush_i) begin
      case (issue_instr_i.fu)
        FU_ALU:            strobe_n.alu = 1'b1;
        FU_BU:             strobe_n.branch = 1'b1;
        FU_LOAD, FU_STORE: strobe_n.lsu = 1'b1;
        FU_MDU:            strobe_n.mdu = 1'b1;
        FU_CSR:            strobe_n.csr = 1'b1;
        default:           strobe_n = '0;
      endcase
    end
  end

  // ------------------------------
  // ID to EX registers
  // ------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      strobe_q         <= '0;
      fu_data_o        <= '0;
      branch_pc_o      <= '0;
      is_compressed_o  <= 1'b0;
      branch_predict_o <= '0;
    end else begin
      strobe_q  <= strobe_n;
      fu_data_o <= fu_data_n;
      // branch side info only tracks branch unit ops
      if (issue_instr_i.fu == FU_BU) begin
        branch_pc_o      <= issue_instr_i.pc;
        is_compressed_o  <= issue_instr_i.is_compressed;
        branch_predict_o <= issue_instr_i.bp;
      end
    end
  end

  assign alu_valid_o    = strobe_q.alu;
  assign branch_valid_o = strobe_q.branch;
  assign lsu_valid_o    = strobe_q.lsu;
  assign mdu_valid_o    = strobe_q.mdu;
  assign csr_valid_o    = strobe_q.csr;

  // at most one unit started per cycle
  strobe_onehot: assert property (@(posedge clock) disable iff (reset) $onehot0(strobe_q));

  // a flushed cycle starts nothing downstream
  flush_kills_strobe: assert property (
    @(posedge clock) disable iff (reset) flush_i |=> (strobe_q == '0)
  );

endmodule

// ==== rtl/operand_forward.sv ====
module operand_forward #(
  parameter int ScoreboardDepth = 8,
  parameter int WriteBackPorts  = 2
) (
  input  logic              clock,
  input  logic [4:0]        rs_i,
  input  sb_pkg::sb_entry_t sb_entries_i [ScoreboardDepth],
  input  sb_pkg::wb_port_t  wb_i [WriteBackPorts],
  output logic              hit_o,
  output logic [31:0]       data_o
);

  localparam int NumReq = WriteBackPorts + ScoreboardDepth;

  // wb ports occupy the low request slots
  logic [NumReq-1:0] req;
  logic [31:0]       req_data [NumReq];

  // ------------------------------
  // request vector
  // ------------------------------
  always_comb begin
    for (int p = 0; p < WriteBackPorts; p++) begin
      // slot must exist, be in flight and target rs
      req[p] = wb_i[p].valid
            && (int'(wb_i[p].trans_id) < ScoreboardDepth)
            && sb_entries_i[wb_i[p].trans_id].issued
            && (sb_entries_i[wb_i[p].trans_id].rd == rs_i);
      req_data[p] = wb_i[p].data;
    end
    // finished entries still waiting for commit
    for (int i = 0; i < ScoreboardDepth; i++) begin
      req[WriteBackPorts+i] = sb_entries_i[i].issued && sb_entries_i[i].valid
                           && (sb_entries_i[i].rd == rs_i);
      req_data[WriteBackPorts+i] = sb_entries_i[i].result;
    end
  end

  // fixed priority with the lowest index winning
  always_comb begin
    hit_o  = 1'b0;
    data_o = '0;
    for (int i = NumReq - 1; i >= 0; i--) begin
      if (req[i]) begin
        hit_o  = 1'b1;
        data_o = req_data[i];
      end
    end
  end

  // flag follows the requests and data comes from the lowest one
  hit_matches_req: assert property (@(posedge clock)
    (hit_o == (|req)) && (!hit_o || (data_o == req_data[$clog2(req & (~req + 1'b1))])));

endmodule

// ==== rtl/clobber_table.sv ====
module clobber_table #(
  parameter int ScoreboardDepth = 8
) (
  input  sb_pkg::sb_entry_t sb_entries_i [ScoreboardDepth],
  input  logic [4:0]        rs1_i,
  input  logic [4:0]        rs2_i,
  input  logic [4:0]        rd_i,
  output logic              rs1_raw_o,
  output logic              rs2_raw_o,
  output logic              rd_waw_o
);

  import isa_pkg::*;

  // unit that will write each gpr
  fu_t clobber [32];

  // ------------------------------
  // build table
  // ------------------------------
  always_comb begin
    for (int r = 0; r < 32; r++) begin
      clobber[r] = FU_NONE;
    end
    // later slots overwrite earlier ones
    // so the highest index wins on a shared rd
    for (int i = 0; i < ScoreboardDepth; i++) begin
      if (sb_entries_i[i].issued) begin
        clobber[sb_entries_i[i].rd] = sb_entries_i[i].fu;
      end
    end
    // x0 never clobbered
    clobber[0] = FU_NONE;
  end

  // lookups
  assign rs1_raw_o = clobber[rs1_i] != FU_NONE;
  assign rs2_raw_o = clobber[rs2_i] != FU_NONE;
  assign rd_waw_o  = (clobber[rd_i] != FU_NONE) && (rd_i != 5'd0);

  // x0 must never look like a pending result
  always_comb begin
    assert (!((rs1_i == 5'd0) && rs1_raw_o) && !((rs2_i == 5'd0) && rs2_raw_o));
  end

endmodule

// ==== rtl/gpr_regfile.sv ====
module gpr_regfile (
  input  logic        clock,
  input  logic        reset,
  input  logic [4:0]  raddr_1_i,
  input  logic [4:0]  raddr_2_i,
  input  logic [4:0]  waddr_i,
  input  logic [31:0] wdata_i,
  input  logic        we_i,
  output logic [31:0] rdata_1_o,
  output logic [31:0] rdata_2_o
);

  // x1..x31 only, x0 has no storage
  logic [31:0] regs [1:31];

  // ------------------------------
  // write port
  // ------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != 5'd0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // ------------------------------
  // read ports
  // ------------------------------
  // same-cycle write not bypassed, old value seen
  assign rdata_1_o = (raddr_1_i == 5'd0) ? 32'd0 : regs[raddr_1_i];
  assign rdata_2_o = (raddr_2_i == 5'd0) ? 32'd0 : regs[raddr_2_i];

endmodule

// ==== rtl/sb_pkg.sv ====
package sb_pkg;

  // ------------------------------
  // scoreboard view seen by issue
  // ------------------------------

  // one scoreboard slot
  // issued means in flight, valid means result already produced
  typedef struct packed {
    logic         issued;
    logic         valid;
    logic [4:0]   rd;
    isa_pkg::fu_t fu;
    logic [31:0]  result;
  } sb_entry_t;

  // write-back port from a functional unit
  // trans_id points at the scoreboard slot being completed
  typedef struct packed {
    logic                            valid;
    logic [isa_pkg::TransIdBits-1:0] trans_id;
    logic [31:0]                     data;
  } wb_port_t;

endpackage

// ==== rtl/isa_pkg.sv ====
package isa_pkg;

  // width of the scoreboard transaction id
  localparam int TransIdBits = 3;

  // ------------------------------
  // functional units and operations
  // ------------------------------
  typedef enum logic [2:0] {
    FU_NONE  = 3'd0,
    FU_ALU   = 3'd1,
    FU_BU    = 3'd2,
    FU_LOAD  = 3'd3,
    FU_STORE = 3'd4,
    FU_MDU   = 3'd5,
    FU_CSR   = 3'd6
  } fu_t;

  // alu, branch, memory, muldiv and csr operations
  typedef enum logic [5:0] {
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
    OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_JAL, OP_JALR,
    OP_LW, OP_LH, OP_LB, OP_LHU, OP_LBU,
    OP_SW, OP_SH, OP_SB,
    OP_MUL, OP_MULH, OP_DIV, OP_DIVU, OP_REM, OP_REMU,
    OP_CSRRW, OP_CSRRS, OP_CSRRC
  } op_t;

  // predicted control flow kind
  typedef enum logic [1:0] {
    CF_NONE,
    CF_BRANCH,
    CF_JUMP,
    CF_RETURN
  } cf_t;

  typedef struct packed {
    cf_t         cf;
    logic [31:0] target;
  } bp_t;

  // ------------------------------
  // decoded instruction from ID
  // ------------------------------
  typedef struct packed {
    logic [31:0]            pc;
    logic [TransIdBits-1:0] trans_id;
    fu_t                    fu;
    op_t                    op;
    logic [4:0]             rs1;
    logic [4:0]             rs2;
    logic [4:0]             rd;
    logic [31:0]            imm;
    logic                   use_imm;
    logic                   use_pc;
    logic                   use_zimm;
    logic                   is_compressed;
    logic                   ex_valid;
    bp_t                    bp;
  } decoder_t;

  // operand bundle towards execute
  typedef struct packed {
    fu_t                    fu;
    op_t                    op;
    logic [31:0]            operand_a;
    logic [31:0]            operand_b;
    logic [31:0]            imm;
    logic [TransIdBits-1:0] trans_id;
  } fu_data_t;

endpackage
